/* Makefile */
VERILATOR := verilator
TOP       := tb_core
FILELIST  := build.f
FLAGS     := --timing --assert --timescale 1ns/100ps
RUN_FLAGS := +verilator+error+limit+100
LOG       := sim.log
FAIL_MSG  := Test failures found
PASS_MSG  := All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported errors"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation ended early"; exit 1)

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

/* build.f */
common/core_pkg.sv
common/rv_isa_pkg.sv
common/ex_issue_if.sv
common/bypass_if.sv
decode/reg_file.sv
decode/decode_stage.sv
execute/execute_stage.sv
src/core_top.sv
sim/core_properties.sv
sim/tb_core.sv

/* common/bypass_if.sv */
`timescale 1ns/100ps

interface bypass_if
    import core_pkg::*;
();
    logic              ex_wr_en;
    logic [REG_AW-1:0] ex_rd;
    logic [XLEN-1:0]   ex_result;    // straight from the alu
    logic              mem_wr_en;
    logic [REG_AW-1:0] mem_rd;
    logic [XLEN-1:0]   mem_result;
    logic              wb_wr_en;
    logic [REG_AW-1:0] wb_rd;
    logic [XLEN-1:0]   wb_result;

    modport source (
        output ex_wr_en, ex_rd, ex_result,
        output mem_wr_en, mem_rd, mem_result,
        output wb_wr_en, wb_rd, wb_result
    );

    modport sink (
        input ex_wr_en, ex_rd, ex_result,
        input mem_wr_en, mem_rd, mem_result,
        input wb_wr_en, wb_rd, wb_result
    );

endinterface

/* common/core_pkg.sv */
package core_pkg;

    localparam int XLEN    = 64;
    localparam int REG_AW  = 5;   // 32 architectural registers
    localparam int SHAMT_W = 6;   // rv64 shift amount

    localparam int ALU_OP_W = 4;

    // alu operation codes
    localparam logic [ALU_OP_W-1:0] ALU_ADD    = 4'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB    = 4'd1;
    localparam logic [ALU_OP_W-1:0] ALU_SLL    = 4'd2;
    localparam logic [ALU_OP_W-1:0] ALU_SLT    = 4'd3;
    localparam logic [ALU_OP_W-1:0] ALU_SLTU   = 4'd4;
    localparam logic [ALU_OP_W-1:0] ALU_XOR    = 4'd5;
    localparam logic [ALU_OP_W-1:0] ALU_SRL    = 4'd6;
    localparam logic [ALU_OP_W-1:0] ALU_SRA    = 4'd7;
    localparam logic [ALU_OP_W-1:0] ALU_OR     = 4'd8;
    localparam logic [ALU_OP_W-1:0] ALU_AND    = 4'd9;
    localparam logic [ALU_OP_W-1:0] ALU_PASS_B = 4'd10;  // lui

endpackage

/* common/ex_issue_if.sv */
`timescale 1ns/100ps

interface ex_issue_if
    import core_pkg::*;
();
    logic                valid;    // legal instr this cycle
    logic [REG_AW-1:0]   rd;
    logic [ALU_OP_W-1:0] alu_op;
    logic [XLEN-1:0]     op_a;     // already forwarded
    logic [XLEN-1:0]     op_b;     // forwarded rs2 or immediate

    modport source (
        output valid, rd, alu_op, op_a, op_b
    );

    modport sink (
        input valid, rd, alu_op, op_a, op_b
    );

endinterface

/* common/rv_isa_pkg.sv */
package rv_isa_pkg;

    // major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    // funct3, shared by reg-reg and reg-imm forms
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam int F7_ALT_BIT = 30;   // funct7[5], picks sub / sra

    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r_fmt;
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_fmt;
        struct packed {
            logic [19:0] imm20;   // upper immediate, bits 31:12
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u_fmt;
    } instr_u;

endpackage

/* decode/decode_stage.sv */
`timescale 1ns/100ps

module decode_stage
    import core_pkg::*;
    import rv_isa_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              instr_valid_i,
    input  logic [31:0]       instr_i,
    output logic [REG_AW-1:0] rf_raddr_a_o,
    output logic [REG_AW-1:0] rf_raddr_b_o,
    input  logic [XLEN-1:0]   rf_rdata_a_i,
    input  logic [XLEN-1:0]   rf_rdata_b_i,
    ex_issue_if.source        issue,
    bypass_if.sink            byp
);
    logic   id_valid_q;
    instr_u id_instr_q;

    logic                dec_legal;
    logic [ALU_OP_W-1:0] dec_alu_op;
    logic                dec_use_imm;
    logic [XLEN-1:0]     dec_imm;
    logic                alt_sel;
    logic                sub_sel;

    logic [REG_AW-1:0] rs_sel  [2];   // 0 is rs1, 1 is rs2
    logic [XLEN-1:0]   rf_data [2];
    logic [XLEN-1:0]   fwd     [2];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            id_valid_q <= 1'b0;
        end else begin
            id_valid_q <= instr_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid_i) begin
            id_instr_q <= instr_i;
        end
    end

    assign alt_sel = id_instr_q[F7_ALT_BIT];
    assign sub_sel = alt_sel && (id_instr_q.r_fmt.opcode == OPC_OP);   // addi has no sub form

    always_comb begin
        dec_legal   = 1'b1;
        dec_use_imm = 1'b0;
        dec_imm     = {{(XLEN-12){id_instr_q.i_fmt.imm12[11]}}, id_instr_q.i_fmt.imm12};

        case (id_instr_q.r_fmt.funct3)
            F3_ADD_SUB: dec_alu_op = sub_sel ? ALU_SUB : ALU_ADD;
            F3_SLL:     dec_alu_op = ALU_SLL;
            F3_SLT:     dec_alu_op = ALU_SLT;
            F3_SLTU:    dec_alu_op = ALU_SLTU;
            F3_XOR:     dec_alu_op = ALU_XOR;
            F3_SRL_SRA: dec_alu_op = alt_sel ? ALU_SRA : ALU_SRL;
            F3_OR:      dec_alu_op = ALU_OR;
            default:    dec_alu_op = ALU_AND;
        endcase

        case (id_instr_q.r_fmt.opcode)
            OPC_OP: begin
                dec_use_imm = 1'b0;
            end
            OPC_OP_IMM: begin
                dec_use_imm = 1'b1;
                if (id_instr_q.i_fmt.funct3 == F3_SLL ||
                    id_instr_q.i_fmt.funct3 == F3_SRL_SRA) begin
                    // shamt only, drop the funct7 bits above it
                    dec_imm = {{(XLEN-SHAMT_W){1'b0}}, id_instr_q.i_fmt.imm12[SHAMT_W-1:0]};
                end
            end
            OPC_LUI: begin
                dec_alu_op  = ALU_PASS_B;
                dec_use_imm = 1'b1;
                dec_imm     = {{(XLEN-32){id_instr_q.u_fmt.imm20[19]}},
                               id_instr_q.u_fmt.imm20, 12'b0};
            end
            default: begin
                dec_legal = 1'b0;   // becomes a bubble
            end
        endcase
    end

    assign rs_sel[0]  = id_instr_q.r_fmt.rs1;
    assign rs_sel[1]  = id_instr_q.r_fmt.rs2;
    assign rf_data[0] = rf_rdata_a_i;
    assign rf_data[1] = rf_rdata_b_i;

    assign rf_raddr_a_o = rs_sel[0];
    assign rf_raddr_b_o = rs_sel[1];

    // youngest producer wins
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            if (rs_sel[i] == '0) begin
                fwd[i] = '0;
            end else if (byp.ex_wr_en && byp.ex_rd == rs_sel[i]) begin
                fwd[i] = byp.ex_result;
            end else if (byp.mem_wr_en && byp.mem_rd == rs_sel[i]) begin
                fwd[i] = byp.mem_result;
            end else if (byp.wb_wr_en && byp.wb_rd == rs_sel[i]) begin
                fwd[i] = byp.wb_result;
            end else begin
                fwd[i] = rf_data[i];
            end
        end
    end

    assign issue.valid  = id_valid_q && dec_legal;
    assign issue.rd     = id_instr_q.r_fmt.rd;
    assign issue.alu_op = dec_alu_op;
    assign issue.op_a   = fwd[0];
    assign issue.op_b   = dec_use_imm ? dec_imm : fwd[1];

endmodule

/* decode/reg_file.sv */
`timescale 1ns/100ps

module reg_file
    import core_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic [REG_AW-1:0] raddr_a_i,
    input  logic [REG_AW-1:0] raddr_b_i,
    output logic [XLEN-1:0]   rdata_a_o,
    output logic [XLEN-1:0]   rdata_b_o,
    input  logic              we_i,
    input  logic [REG_AW-1:0] waddr_i,
    input  logic [XLEN-1:0]   wdata_i
);
    logic [XLEN-1:0] regs_q [1:2**REG_AW-1];   // no storage for x0

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 2**REG_AW; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    // x0 reads as zero
    assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

/* execute/execute_stage.sv */
`timescale 1ns/100ps

module execute_stage
    import core_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n_i,
    ex_issue_if.sink          issue,
    bypass_if.source          byp,
    output logic              rf_we_o,
    output logic [REG_AW-1:0] rf_waddr_o,
    output logic [XLEN-1:0]   rf_wdata_o,
    output logic              wb_valid_o,
    output logic [REG_AW-1:0] wb_rd_o,
    output logic [XLEN-1:0]   wb_data_o
);
    logic                ex_valid_q;
    logic [REG_AW-1:0]   ex_rd_q;
    logic [ALU_OP_W-1:0] ex_alu_op_q;
    logic [XLEN-1:0]     ex_op_a_q;
    logic [XLEN-1:0]     ex_op_b_q;

    logic [SHAMT_W-1:0]  shamt;
    logic [XLEN-1:0]     alu_result;

    logic                mem_valid_q;
    logic [REG_AW-1:0]   mem_rd_q;
    logic [XLEN-1:0]     mem_result_q;

    logic                wb_valid_q;
    logic [REG_AW-1:0]   wb_rd_q;
    logic [XLEN-1:0]     wb_result_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex_valid_q  <= 1'b0;
            mem_valid_q <= 1'b0;
            wb_valid_q  <= 1'b0;
        end else begin
            ex_valid_q  <= issue.valid;
            mem_valid_q <= ex_valid_q;
            wb_valid_q  <= mem_valid_q;
        end
    end

    // EX register
    always_ff @(posedge clk) begin
        if (issue.valid) begin
            ex_rd_q     <= issue.rd;
            ex_alu_op_q <= issue.alu_op;
            ex_op_a_q   <= issue.op_a;
            ex_op_b_q   <= issue.op_b;
        end
    end

    assign shamt = ex_op_b_q[SHAMT_W-1:0];

    always_comb begin
        case (ex_alu_op_q)
            ALU_ADD:    alu_result = ex_op_a_q + ex_op_b_q;
            ALU_SUB:    alu_result = ex_op_a_q - ex_op_b_q;
            ALU_SLL:    alu_result = ex_op_a_q << shamt;
            ALU_SLT:    alu_result = {{(XLEN-1){1'b0}}, $signed(ex_op_a_q) < $signed(ex_op_b_q)};
            ALU_SLTU:   alu_result = {{(XLEN-1){1'b0}}, ex_op_a_q < ex_op_b_q};
            ALU_XOR:    alu_result = ex_op_a_q ^ ex_op_b_q;
            ALU_SRL:    alu_result = ex_op_a_q >> shamt;
            ALU_SRA:    alu_result = $unsigned($signed(ex_op_a_q) >>> shamt);
            ALU_OR:     alu_result = ex_op_a_q | ex_op_b_q;
            ALU_AND:    alu_result = ex_op_a_q & ex_op_b_q;
            ALU_PASS_B: alu_result = ex_op_b_q;   // lui
            default:    alu_result = '0;
        endcase
    end

    // MEM register, no memory access left so it only delays
    always_ff @(posedge clk) begin
        if (ex_valid_q) begin
            mem_rd_q     <= ex_rd_q;
            mem_result_q <= alu_result;
        end
    end

    // WB register
    always_ff @(posedge clk) begin
        if (mem_valid_q) begin
            wb_rd_q     <= mem_rd_q;
            wb_result_q <= mem_result_q;
        end
    end

    // forwarding taps, x0 never forwards
    assign byp.ex_wr_en   = ex_valid_q && (ex_rd_q != '0);
    assign byp.ex_rd      = ex_rd_q;
    assign byp.ex_result  = alu_result;
    assign byp.mem_wr_en  = mem_valid_q && (mem_rd_q != '0);
    assign byp.mem_rd     = mem_rd_q;
    assign byp.mem_result = mem_result_q;
    assign byp.wb_wr_en   = rf_we_o;
    assign byp.wb_rd      = wb_rd_q;
    assign byp.wb_result  = wb_result_q;

    assign rf_we_o    = wb_valid_q && (wb_rd_q != '0);
    assign rf_waddr_o = wb_rd_q;
    assign rf_wdata_o = wb_result_q;

    assign wb_valid_o = wb_valid_q;   // x0 writes still retire here
    assign wb_rd_o    = wb_rd_q;
    assign wb_data_o  = wb_result_q;

endmodule

/* sim/core_properties.sv */
`timescale 1ns/100ps

module core_properties
    import core_pkg::*;
(
    input logic              clk,
    input logic              rst_n_i,
    input logic              instr_valid_i,
    input logic              wb_valid_i,
    input logic [REG_AW-1:0] wb_rd_i
);
    int fail_count = 0;

    quiet_in_reset: assert property (@(posedge clk) !rst_n_i |-> !wb_valid_i)
        else begin
            $error("wb_valid_o high while reset is held");
            fail_count++;
        end

    // the edge that took the instruction lies 4 samples back
    has_origin: assert property (@(posedge clk) disable iff (!rst_n_i)
        wb_valid_i |-> $past(instr_valid_i, 4))
        else begin
            $error("wb_valid_o without an instruction three cycles before");
            fail_count++;
        end

    rd_known: assert property (@(posedge clk) disable iff (!rst_n_i)
        wb_valid_i |-> !$isunknown(wb_rd_i))
        else begin
            $error("wb_rd_o unknown while wb_valid_o is high");
            fail_count++;
        end

endmodule

bind core_top core_properties u_props (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .instr_valid_i (instr_valid_i),
    .wb_valid_i    (wb_valid_o),
    .wb_rd_i       (wb_rd_o)
);

/* sim/core_stimulus.hex */
// gap instr legal rd value, one record per line; gap ff means 4 to 11 random idle cycles
// legal 0 means the opcode must retire nothing, legal f ends the list
00 123450B7 1 01 0000000012345000 // lui x1
00 FFB00113 1 02 FFFFFFFFFFFFFFFB
00 07F00193 1 03 000000000000007F
00 80000237 1 04 FFFFFFFF80000000
00 003082B3 1 05 000000001234507F // add, x3 from mem
00 40518333 1 06 FFFFFFFFEDCBB000 // sub, x5 from ex, x3 from wb
00 003193B3 1 07 8000000000000000
00 00232433 1 08 0000000000000001
00 003134B3 1 09 0000000000000000
00 0020C533 1 0a FFFFFFFFEDCBAFFB
00 003255B3 1 0b 0000000000000001
00 40325633 1 0c FFFFFFFFFFFFFFFF
00 0015E6B3 1 0d 0000000012345001
00 00567733 1 0e 000000001234507F
00 FFF12793 1 0f 0000000000000001
00 0027B813 1 10 0000000000000001
00 0F00C893 1 11 00000000123450F0
00 7001E913 1 12 000000000000077F
00 0FF17993 1 13 00000000000000FB
00 02419A13 1 14 000007F000000000
00 00425A93 1 15 0FFFFFFFF8000000
00 40425B13 1 16 FFFFFFFFF8000000
02 00518013 1 00 0000000000000084 // write to x0
00 00000BB3 1 17 0000000000000000
00 0000B283 0 00 0000000000000000 // ld x5, not supported
00 00128C13 1 18 0000000012345080
ff 002C0CB3 1 19 000000001234507B
ff F80C8D13 1 1a 0000000012344FFB
ff 401D0DB3 1 1b FFFFFFFFFFFFFFFB
00 00000000 f 00 0000000000000000

/* sim/tb_core.sv */
`timescale 1ns/100ps

module tb_core
    import core_pkg::*;
();

    localparam int          MAX_REC    = 64;
    localparam int          FIELDS     = 5;       // gap, instr, legal, rd, value
    localparam logic [63:0] RANDOM_GAP = 64'hff;

    logic              clk;
    logic              rst_n_i;
    logic              instr_valid_i;
    logic [31:0]       instr_i;
    logic              wb_valid_o;
    logic [REG_AW-1:0] wb_rd_o;
    logic [XLEN-1:0]   wb_data_o;

    logic [63:0] stim_mem [0:FIELDS*MAX_REC-1];
    int          gap      [MAX_REC];
    int          exp_q    [$];   // record numbers waiting to retire
    int          num_rec;
    int          gap_sum;
    int          cycle_cnt;
    int          cycle_limit;
    int          checks;
    int          errors;
    int          seed;

    core_top dut (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .wb_valid_o    (wb_valid_o),
        .wb_rd_o       (wb_rd_o),
        .wb_data_o     (wb_data_o)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout after %0d cycles, %0d results never arrived",
                     cycle_cnt, exp_q.size());
            $display("Test failures found");
            $finish;
        end
    end

    task automatic check_output();
        int          rec;
        logic [63:0] exp_rd;
        logic [63:0] exp_val;
        bit          ok;
        if (!wb_valid_o) begin
            return;
        end
        if (exp_q.size() == 0) begin
            $display("extra result on x%0d with no instruction left to retire", wb_rd_o);
            errors++;
            return;
        end
        rec     = exp_q.pop_front();   // in-order retire
        ok      = 1'b1;
        exp_rd  = stim_mem[FIELDS*rec+3];
        exp_val = stim_mem[FIELDS*rec+4];
        checks++;
        if (wb_rd_o != exp_rd[REG_AW-1:0]) begin
            $display("ERR wb_rd_o expected %h got %h (record %0d)",
                     exp_rd[REG_AW-1:0], wb_rd_o, rec);
            ok = 1'b0;
        end
        if (wb_data_o != exp_val) begin
            $display("ERR wb_data_o expected %h got %h (record %0d)", exp_val, wb_data_o, rec);
            ok = 1'b0;
        end
        if (!ok) begin
            errors++;
        end
        $display("record %0d x%0d: %s", rec, exp_rd[REG_AW-1:0], ok ? "ok" : "mismatch");
    endtask

    // outputs are stable at the falling edge, inputs change there too
    task automatic drive_cycle(input logic valid, input logic [31:0] word);
        @(negedge clk);
        check_output();
        instr_valid_i = valid;
        instr_i       = word;
    endtask

    initial begin
        int          base;
        logic [31:0] word;
        clk           = 1'b0;
        rst_n_i       = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        seed          = 32'ha0e1411e;
        cycle_cnt     = 0;
        checks        = 0;
        errors        = 0;
        gap_sum       = 0;
        num_rec       = 0;
        $readmemh("sim/core_stimulus.hex", stim_mem);

        // legal field above 1 marks the end of the list
        while (num_rec < MAX_REC && stim_mem[FIELDS*num_rec+2] <= 64'd1) begin
            base = FIELDS * num_rec;
            if (stim_mem[base] == RANDOM_GAP) begin
                gap[num_rec] = 4 + ($random(seed) & 7);
            end else begin
                gap[num_rec] = int'(stim_mem[base]);
            end
            gap_sum += gap[num_rec];
            num_rec++;
        end
        cycle_limit = 4 * num_rec + gap_sum + 50;

        repeat (8) @(negedge clk);
        rst_n_i = 1'b1;

        for (int rec = 0; rec < num_rec; rec++) begin
            base = FIELDS * rec;
            word = stim_mem[base+1][31:0];
            repeat (gap[rec]) drive_cycle(1'b0, 32'h0);
            drive_cycle(1'b1, word);
            if (stim_mem[base+2] == 64'd1) begin
                exp_q.push_back(rec);
            end else begin
                $display("record %0d: illegal opcode %h, no result expected", rec, word);
            end
        end

        drive_cycle(1'b0, 32'h0);
        while (exp_q.size() > 0) begin
            drive_cycle(1'b0, 32'h0);
        end
        repeat (4) drive_cycle(1'b0, 32'h0);   // window for stray results

        $display("done: %0d records, %0d results checked, %0d errors, %0d assertion failures",
                 num_rec, checks, errors, dut.u_props.fail_count);
        if (errors == 0 && dut.u_props.fail_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* src/core_top.sv */
`timescale 1ns/100ps

module core_top
    import core_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              instr_valid_i,
    input  logic [31:0]       instr_i,
    output logic              wb_valid_o,
    output logic [REG_AW-1:0] wb_rd_o,
    output logic [XLEN-1:0]   wb_data_o
);
    logic [REG_AW-1:0] rf_raddr_a;
    logic [REG_AW-1:0] rf_raddr_b;
    logic [XLEN-1:0]   rf_rdata_a;
    logic [XLEN-1:0]   rf_rdata_b;
    logic              rf_we;
    logic [REG_AW-1:0] rf_waddr;
    logic [XLEN-1:0]   rf_wdata;

    ex_issue_if issue_if ();
    bypass_if   byp_if ();

    decode_stage u_decode (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .rf_raddr_a_o  (rf_raddr_a),
        .rf_raddr_b_o  (rf_raddr_b),
        .rf_rdata_a_i  (rf_rdata_a),
        .rf_rdata_b_i  (rf_rdata_b),
        .issue         (issue_if.source),
        .byp           (byp_if.sink)
    );

    execute_stage u_execute (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .issue      (issue_if.sink),
        .byp        (byp_if.source),
        .rf_we_o    (rf_we),
        .rf_waddr_o (rf_waddr),
        .rf_wdata_o (rf_wdata),
        .wb_valid_o (wb_valid_o),
        .wb_rd_o    (wb_rd_o),
        .wb_data_o  (wb_data_o)
    );

    reg_file u_reg_file (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .raddr_a_i (rf_raddr_a),
        .raddr_b_i (rf_raddr_b),
        .rdata_a_o (rf_rdata_a),
        .rdata_b_o (rf_rdata_b),
        .we_i      (rf_we),
        .waddr_i   (rf_waddr),
        .wdata_i   (rf_wdata)
    );

endmodule
